// ==== logic/wr_pkg.sv ====
/*
 * Shared widths, counts and types for the memory write-request path.
 * Imported by every RTL module and by the testbench. Request and
 * sequence entries travel as packed structs.
 */

package wr_pkg;

  // --------------------
  // Channel widths and counts
  // --------------------

  // Peer destinations sharing the write channel
  localparam int N_DESTS       = 4;
  localparam int DEST_BITS     = 2;

  // Write data beat, 8 bytes
  localparam int DATA_BITS     = 64;
  localparam int BEAT_LOG_BITS = 3;

  // Beat count minus one
  localparam int BLEN_BITS     = 13;

  // Request field widths
  localparam int PID_BITS      = 6;
  localparam int VADDR_BITS    = 32;
  localparam int LEN_BITS      = 16;

  // Sequence entries in flight between arbiter and data mux
  localparam int N_OUTSTANDING = 8;

  // --------------------
  // Plain vector types
  // --------------------

  typedef logic [DEST_BITS-1:0]  dest_t;
  typedef logic [PID_BITS-1:0]   pid_t;
  typedef logic [VADDR_BITS-1:0] vaddr_t;
  // Byte length, never zero
  typedef logic [LEN_BITS-1:0]   len_t;
  typedef logic [DATA_BITS-1:0]  data_t;
  typedef logic [BLEN_BITS-1:0]  blen_t;

  // --------------------
  // Structs and enums
  // --------------------

  // One write request, 54 bits
  typedef struct packed {
    vaddr_t vaddr;
    len_t   len;
    pid_t   pid;
  } dreq_t;

  // Mux sequence entry, len holds beats minus one
  typedef struct packed {
    pid_t  pid;
    blen_t len;
    dest_t dest;
  } mux_user_t;

  // Data mux states
  typedef enum logic {
    MUX_IDLE,
    MUX_BURST
  } mux_state_t;

endpackage

// ==== logic/meta_reg.sv ====
/*
 * Two-entry register slice for the request channel.
 * Main register plus skid register, ready comes from a flop.
 * Full throughput, one cycle from input transfer to output valid.
 */

`timescale 1ns/1ps

module meta_reg import wr_pkg::*; (
  input  logic  aclk,
  input  logic  aresetn,
  input  logic  s_valid,
  output logic  s_ready,
  input  dreq_t s_data,
  output logic  m_valid,
  input  logic  m_ready,
  output dreq_t m_data
);

  logic  skid_valid;
  logic  skid_valid_n;
  logic  m_valid_n;
  logic  s_fire;
  logic  load;
  dreq_t skid_data;

  assign s_fire = s_valid & s_ready;
  // Output register free to take a new entry
  assign load   = m_ready | ~m_valid;

  // Next occupancy of both entries
  always_comb begin
    m_valid_n    = m_valid;
    skid_valid_n = skid_valid;
    if (load) begin
      // Skid entry drains first, input is stalled meanwhile
      m_valid_n    = skid_valid | s_fire;
      skid_valid_n = 1'b0;
    end else if (s_fire) begin
      skid_valid_n = 1'b1;
    end
  end

  // Control flops, ready held low in reset
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
      s_ready    <= 1'b0;
    end else begin
      m_valid    <= m_valid_n;
      skid_valid <= skid_valid_n;
      s_ready    <= ~skid_valid_n;
    end
  end

  // Payload
  always_ff @(posedge aclk) begin
    if (load) begin
      m_data <= skid_valid ? skid_data : s_data;
    end else if (s_fire) begin
      skid_data <= s_data;
    end
  end

endmodule

// ==== logic/seq_queue.sv ====
/*
 * Circular FIFO of mux sequence entries.
 * Filled by the arbiter on every grant, drained by the data mux.
 * Push and pop may happen in the same cycle, depth set by QDEPTH.
 */

`timescale 1ns/1ps

module seq_queue import wr_pkg::*; #(
  parameter int QDEPTH = N_OUTSTANDING
) (
  input  logic      aclk,
  input  logic      aresetn,
  input  logic      push_valid,
  output logic      push_ready,
  input  mux_user_t push_data,
  output logic      pop_valid,
  input  logic      pop_ready,
  output mux_user_t pop_data
);

  // Entry storage
  mux_user_t mem [QDEPTH];

  logic [$clog2(QDEPTH)-1:0]   wr_ptr;
  logic [$clog2(QDEPTH)-1:0]   rd_ptr;
  logic [$clog2(QDEPTH+1)-1:0] count;
  logic push_fire;
  logic pop_fire;

  // Full refuses push, empty hides head
  assign push_ready = (count != QDEPTH);
  assign pop_valid  = (count != 0);
  assign pop_data   = mem[rd_ptr];

  assign push_fire = push_valid & push_ready;
  assign pop_fire  = pop_valid & pop_ready;

  // --------------------
  // Pointers and count
  // --------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr <= (wr_ptr == QDEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr <= (rd_ptr == QDEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves count alone
      if (push_fire && !pop_fire) begin
        count <= count + 1'b1;
      end else if (pop_fire && !push_fire) begin
        count <= count - 1'b1;
      end
    end
  end

  // Write port
  always_ff @(posedge aclk) begin
    if (push_fire) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

// ==== logic/dreq_wr_arb.sv ====
/*
 * Round-robin arbiter over destination write requests.
 * Forwards the winner to the request sink and, in the same cycle,
 * pushes its mux sequence entry. The pointer steps by one per grant.
 */

`timescale 1ns/1ps

module dreq_wr_arb import wr_pkg::*; (
  input  logic               aclk,
  input  logic               aresetn,
  // Destination requests
  input  logic [N_DESTS-1:0] s_req_valid,
  output logic [N_DESTS-1:0] s_req_ready,
  input  dreq_t              s_req [N_DESTS],
  // Granted request
  output logic               m_req_valid,
  input  logic               m_req_ready,
  output dreq_t              m_req,
  // Mux sequence push
  output logic               seq_valid,
  input  logic               seq_ready,
  output mux_user_t          seq
);

  dest_t rr_ptr;
  dest_t winner;
  logic  any_valid;
  logic  grant;
  dreq_t win_req;

  // --------------------
  // Winner select
  // --------------------
  // Scan upward from pointer, wrap at N_DESTS
  always_comb begin
    dest_t cand;
    any_valid = 1'b0;
    winner    = '0;
    for (int i = 0; i < N_DESTS; i++) begin
      cand = dest_t'((int'(rr_ptr) + i) % N_DESTS);
      if (!any_valid && s_req_valid[cand]) begin
        any_valid = 1'b1;
        winner    = cand;
      end
    end
  end

  assign win_req = s_req[winner];

  // Grant needs both the request sink and the queue
  assign grant = any_valid & m_req_ready & seq_ready;

  // Each side sees valid only if the other can take it too
  assign m_req_valid = any_valid & seq_ready;
  assign seq_valid   = any_valid & m_req_ready;
  assign m_req       = win_req;

  // Ready only toward the winner
  always_comb begin
    s_req_ready = '0;
    s_req_ready[winner] = grant;
  end

  // --------------------
  // Sequence entry
  // --------------------
  // Beats minus one from byte length
  assign seq.pid  = win_req.pid;
  assign seq.len  = blen_t'((win_req.len - len_t'(1)) >> BEAT_LOG_BITS);
  assign seq.dest = winner;

  // Pointer steps by one, not to winner plus one
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rr_ptr <= '0;
    end else if (grant) begin
      rr_ptr <= (rr_ptr == dest_t'(N_DESTS - 1)) ? '0 : rr_ptr + 1'b1;
    end
  end

endmodule

// ==== logic/wr_data_mux.sv ====
/*
 * Write-data multiplexer.
 * Pops one sequence entry, then steers that many beats from the named
 * destination onto the output channel and flags the final beat with last.
 */

`timescale 1ns/1ps

module wr_data_mux import wr_pkg::*; (
  input  logic               aclk,
  input  logic               aresetn,
  // Sequence entries from the queue
  input  logic               seq_valid,
  output logic               seq_ready,
  input  mux_user_t          seq,
  // Destination data
  input  logic [N_DESTS-1:0] s_data_valid,
  output logic [N_DESTS-1:0] s_data_ready,
  input  data_t              s_data [N_DESTS],
  // Outgoing data
  output logic               m_data_valid,
  input  logic               m_data_ready,
  output data_t              m_data,
  output logic               m_data_last
);

  mux_state_t state;
  dest_t      cur_dest;
  blen_t      cur_len;
  blen_t      beat_cnt;
  logic       in_burst;
  logic       beat_fire;

  assign in_burst = (state == MUX_BURST);

  // Take an entry only while idle
  assign seq_ready = (state == MUX_IDLE);

  // --------------------
  // Beat steering
  // --------------------
  assign m_data_valid = in_burst & s_data_valid[cur_dest];
  assign m_data       = s_data[cur_dest];
  assign m_data_last  = in_burst & (beat_cnt == cur_len);
  assign beat_fire    = m_data_valid & m_data_ready;

  // Ready passes back to the chosen destination only
  always_comb begin
    s_data_ready = '0;
    s_data_ready[cur_dest] = in_burst & m_data_ready;
  end

  // --------------------
  // Burst FSM
  // --------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state    <= MUX_IDLE;
      cur_dest <= '0;
      cur_len  <= '0;
      beat_cnt <= '0;
    end else begin
      case (state)
        MUX_IDLE: begin
          if (seq_valid) begin
            // Latch route and beat count
            cur_dest <= seq.dest;
            cur_len  <= seq.len;
            beat_cnt <= '0;
            state    <= MUX_BURST;
          end
        end
        MUX_BURST: begin
          if (beat_fire) begin
            if (m_data_last) begin
              state <= MUX_IDLE;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        default: state <= MUX_IDLE;
      endcase
    end
  end

endmodule

// ==== logic/wr_path_top.sv ====
/*
 * Write-request path top level.
 * Arbiter, request register slice, sequence queue and data mux.
 */

`timescale 1ns/1ps

module wr_path_top import wr_pkg::*; (
  input  logic               aclk,
  input  logic               aresetn,
  // Destination requests
  input  logic [N_DESTS-1:0] s_req_valid,
  output logic [N_DESTS-1:0] s_req_ready,
  input  dreq_t              s_req [N_DESTS],
  // Destination data
  input  logic [N_DESTS-1:0] s_data_valid,
  output logic [N_DESTS-1:0] s_data_ready,
  input  data_t              s_data [N_DESTS],
  // Outgoing request
  output logic               m_req_valid,
  input  logic               m_req_ready,
  output dreq_t              m_req,
  // Outgoing data
  output logic               m_data_valid,
  input  logic               m_data_ready,
  output data_t              m_data,
  output logic               m_data_last
);

  // Arbiter to register slice
  logic      arb_req_valid;
  logic      arb_req_ready;
  dreq_t     arb_req;

  // Arbiter to queue
  logic      seq_in_valid;
  logic      seq_in_ready;
  mux_user_t seq_in;

  // Queue to data mux
  logic      seq_out_valid;
  logic      seq_out_ready;
  mux_user_t seq_out;

  dreq_wr_arb u_arb (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .s_req_valid (s_req_valid),
    .s_req_ready (s_req_ready),
    .s_req       (s_req),
    .m_req_valid (arb_req_valid),
    .m_req_ready (arb_req_ready),
    .m_req       (arb_req),
    .seq_valid   (seq_in_valid),
    .seq_ready   (seq_in_ready),
    .seq         (seq_in)
  );

  meta_reg u_req_reg (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (arb_req_valid),
    .s_ready (arb_req_ready),
    .s_data  (arb_req),
    .m_valid (m_req_valid),
    .m_ready (m_req_ready),
    .m_data  (m_req)
  );

  seq_queue #(
    .QDEPTH (N_OUTSTANDING)
  ) u_seq_queue (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .push_valid (seq_in_valid),
    .push_ready (seq_in_ready),
    .push_data  (seq_in),
    .pop_valid  (seq_out_valid),
    .pop_ready  (seq_out_ready),
    .pop_data   (seq_out)
  );

  wr_data_mux u_data_mux (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .seq_valid    (seq_out_valid),
    .seq_ready    (seq_out_ready),
    .seq          (seq_out),
    .s_data_valid (s_data_valid),
    .s_data_ready (s_data_ready),
    .s_data       (s_data),
    .m_data_valid (m_data_valid),
    .m_data_ready (m_data_ready),
    .m_data       (m_data),
    .m_data_last  (m_data_last)
  );

endmodule

// ==== testbench/tb_clock.sv ====
/*
 * Testbench clock and reset source.
 * 4 ns clock. Active-low reset held for 8 cycles, released on a falling edge.
 */

`timescale 1ns/1ps

module tb_clock (
  output logic aclk,
  output logic aresetn
);

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  // Eight rising edges in reset, DUT sees the release at the next rise
  initial begin
    aresetn = 1'b0;
    repeat (8) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;
  end

endmodule

// ==== testbench/wr_path_tb.sv ====
/*
 * Testbench for the write-request path, acting as the memory side.
 * Random requests and beats from an xorshift source are checked against a
 * per-destination model. Inputs change on the falling edge, outputs are
 * sampled 1 ns later, so a transfer seen there completes at the next rise.
 */

`timescale 1ns/1ps

module wr_path_tb import wr_pkg::*; ();

  localparam int N_REQ        = 50;
  localparam int TOTAL_REQ    = N_DESTS * N_REQ;
  localparam int N_RR         = 24;
  localparam int STALL_AT     = 60;
  localparam int STALL_CYCLES = 200;
  localparam int MAX_CYCLES   = 20000;
  localparam int RST_TIMEOUT  = 20;

  logic               aclk;
  logic               aresetn;
  logic [N_DESTS-1:0] s_req_valid;
  logic [N_DESTS-1:0] s_req_ready;
  dreq_t              s_req [N_DESTS];
  logic [N_DESTS-1:0] s_data_valid;
  logic [N_DESTS-1:0] s_data_ready;
  data_t              s_data [N_DESTS];
  logic               m_req_valid;
  logic               m_req_ready;
  dreq_t              m_req;
  logic               m_data_valid;
  logic               m_data_ready;
  data_t              m_data;
  logic               m_data_last;

  // --------------------
  // Model state
  // --------------------
  int req_len [N_DESTS][N_REQ];
  int req_pid [N_DESTS][N_REQ];
  // Next request offered per destination
  int req_idx [N_DESTS];
  // Next request expected on m_req
  int seen [N_DESTS];
  // Data stream position by request and beat
  int dat_k [N_DESTS];
  int dat_b [N_DESTS];
  logic [N_DESTS-1:0] req_busy;
  logic [N_DESTS-1:0] dat_busy;
  // Grant order taken at the arbiter inputs
  int g_dest [TOTAL_REQ];
  int g_seq [TOTAL_REQ];
  int g_cnt;
  int data_idx;
  int beat_i;
  int n_mreq;
  int n_beats;
  int errors;
  int timeouts;
  int stall_left;
  int g_mid;
  logic stall_done;
  logic bound_hit;
  logic [31:0] rng;

  tb_clock u_clock (
    .aclk    (aclk),
    .aresetn (aresetn)
  );

  wr_path_top UUT (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .s_req_valid  (s_req_valid),
    .s_req_ready  (s_req_ready),
    .s_req        (s_req),
    .s_data_valid (s_data_valid),
    .s_data_ready (s_data_ready),
    .s_data       (s_data),
    .m_req_valid  (m_req_valid),
    .m_req_ready  (m_req_ready),
    .m_req        (m_req),
    .m_data_valid (m_data_valid),
    .m_data_ready (m_data_ready),
    .m_data       (m_data),
    .m_data_last  (m_data_last)
  );

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Byte length rounded up to whole 8-byte beats
  function automatic int beat_count(int len);
    return (len + (1 << BEAT_LOG_BITS) - 1) / (1 << BEAT_LOG_BITS);
  endfunction

  function automatic data_t beat_value(int d, int k, int b);
    return {14'h0, 2'(d), 16'(k), 32'(b)};
  endfunction

  // Destination in vaddr[29:28] and sequence number in vaddr[27:12]
  function automatic dreq_t make_req(int d, int k);
    dreq_t r;
    r.vaddr = {2'b00, 2'(d), 16'(k), 12'h000};
    r.len   = len_t'(req_len[d][k]);
    r.pid   = pid_t'(req_pid[d][k]);
    return r;
  endfunction

  task automatic report_mismatch(string name, logic [63:0] exp, logic [63:0] act);
    errors++;
    $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
  endtask

  task automatic check_idle_outputs();
    if (m_req_valid !== 1'b0) report_mismatch("m_req_valid", 64'd0, 64'(m_req_valid));
    if (m_data_valid !== 1'b0) report_mismatch("m_data_valid", 64'd0, 64'(m_data_valid));
    if (m_data_last !== 1'b0) report_mismatch("m_data_last", 64'd0, 64'(m_data_last));
    if (s_req_ready !== '0) report_mismatch("s_req_ready", 64'd0, 64'(s_req_ready));
    if (s_data_ready !== '0) report_mismatch("s_data_ready", 64'd0, 64'(s_data_ready));
  endtask

  // --------------------
  // Falling edge drive
  // --------------------
  task automatic drive_inputs();
    logic rr_phase;
    rng = xorshift32(rng);
    // Round-robin phase keeps every request valid and m_req open
    rr_phase = (n_mreq < N_RR);
    for (int d = 0; d < N_DESTS; d++) begin
      if (!req_busy[d] && req_idx[d] < N_REQ && (rr_phase || rng[2*d +: 2] != 2'b00)) begin
        req_busy[d] = 1'b1;
      end
      if (req_idx[d] < N_REQ) s_req[d] = make_req(d, req_idx[d]);
      s_req_valid[d] = req_busy[d];
      if (!dat_busy[d] && dat_k[d] < N_REQ && rng[8 + 2*d +: 2] != 2'b00) begin
        dat_busy[d] = 1'b1;
      end
      if (dat_k[d] < N_REQ) s_data[d] = beat_value(d, dat_k[d], dat_b[d]);
      s_data_valid[d] = dat_busy[d];
    end
    if (!stall_done && stall_left == 0 && g_cnt >= STALL_AT) stall_left = STALL_CYCLES;
    m_req_ready  = rr_phase ? 1'b1 : rng[16];
    m_data_ready = (stall_left == 0) && (rng[18:17] != 2'b00);
  endtask

  // --------------------
  // Sampling and checks
  // --------------------
  task automatic sample_outputs();
    int d;
    int nb;
    dreq_t exp_req;
    data_t exp_data;
    for (int i = 0; i < N_DESTS; i++) begin
      if (s_req_valid[i] && s_req_ready[i]) begin
        g_dest[g_cnt] = i;
        g_seq[g_cnt]  = req_idx[i];
        g_cnt++;
        req_idx[i]++;
        req_busy[i] = 1'b0;
      end
      if (s_data_valid[i] && s_data_ready[i]) begin
        dat_busy[i] = 1'b0;
        if (dat_b[i] == beat_count(req_len[i][dat_k[i]]) - 1) begin
          dat_k[i]++;
          dat_b[i] = 0;
        end else begin
          dat_b[i]++;
        end
      end
    end
    // Outgoing request against per-destination order
    if (m_req_valid && m_req_ready) begin
      d = int'(m_req.vaddr[29:28]);
      if (seen[d] >= N_REQ) begin
        errors++;
        $display("Extra request on m_req for destination %0d at t=%0t", d, $time);
      end else begin
        exp_req = make_req(d, seen[d]);
        if (m_req !== exp_req) report_mismatch("m_req", {10'd0, exp_req}, {10'd0, m_req});
        seen[d]++;
      end
      // Register slice keeps the grant order across destinations
      if (n_mreq < g_cnt && d != g_dest[n_mreq]) begin
        report_mismatch("m_req grant dest", 64'(g_dest[n_mreq]), 64'(d));
      end
      if (n_mreq < N_RR && d != n_mreq % N_DESTS) begin
        report_mismatch("m_req dest", 64'(n_mreq % N_DESTS), 64'(d));
      end
      n_mreq++;
    end
    // Outgoing beat against the grant order
    if (m_data_valid && m_data_ready) begin
      if (data_idx >= g_cnt) begin
        errors++;
        $display("Beat on m_data with no granted request at t=%0t", $time);
      end else begin
        nb = beat_count(req_len[g_dest[data_idx]][g_seq[data_idx]]);
        exp_data = beat_value(g_dest[data_idx], g_seq[data_idx], beat_i);
        if (m_data !== exp_data) report_mismatch("m_data", exp_data, m_data);
        if (m_data_last !== (beat_i == nb - 1)) begin
          report_mismatch("m_data_last", 64'(beat_i == nb - 1), 64'(m_data_last));
        end
        if (beat_i == nb - 1) begin
          data_idx++;
          beat_i = 0;
        end else begin
          beat_i++;
        end
      end
      n_beats++;
    end
    // Grants in flight bounded by queue depth plus the burst in the mux
    if (stall_left > 0) begin
      if (g_cnt - data_idx > N_OUTSTANDING + 1 && !bound_hit) begin
        bound_hit = 1'b1;
        errors++;
        $display("Grants ran ahead of stalled data: %0d in flight", g_cnt - data_idx);
      end
      if (stall_left == STALL_CYCLES / 2) g_mid = g_cnt;
      if (stall_left == 1) begin
        if (g_cnt != g_mid) report_mismatch("grants under stall", 64'(g_mid), 64'(g_cnt));
        stall_done = 1'b1;
      end
      stall_left--;
    end
  endtask

  initial begin
    int rst_wait;
    int cycle;
    logic done;
    rng = 32'd2033;
    errors = 0;
    timeouts = 0;
    g_cnt = 0;
    data_idx = 0;
    beat_i = 0;
    n_mreq = 0;
    n_beats = 0;
    stall_left = 0;
    g_mid = 0;
    stall_done = 1'b0;
    bound_hit = 1'b0;
    for (int d = 0; d < N_DESTS; d++) begin
      for (int k = 0; k < N_REQ; k++) begin
        rng = xorshift32(rng);
        req_len[d][k] = int'(rng[5:0]) + 1;
        req_pid[d][k] = int'(rng[13:8]);
      end
    end
    // Shortest and longest bursts early on
    req_len[0][0] = 1;
    req_len[1][0] = 64;
    for (int d = 0; d < N_DESTS; d++) begin
      req_idx[d] = 0;
      seen[d] = 0;
      dat_k[d] = 0;
      dat_b[d] = 0;
      s_req[d] = make_req(d, 0);
      s_data[d] = beat_value(d, 0, 0);
    end
    // All requests valid from reset for the round-robin phase
    req_busy = '1;
    dat_busy = '0;
    s_req_valid = '1;
    s_data_valid = '0;
    m_req_ready = 1'b1;
    m_data_ready = 1'b0;

    // Idle outputs through reset and just after release
    @(posedge aclk);
    rst_wait = 0;
    do begin
      @(negedge aclk);
      #1;
      check_idle_outputs();
      rst_wait++;
    end while (!aresetn && rst_wait < RST_TIMEOUT);
    if (!aresetn) begin
      timeouts++;
      $display("Timeout: reset was never released");
    end

    if (timeouts == 0) begin
      cycle = 0;
      done = 1'b0;
      while (!done && cycle < MAX_CYCLES) begin
        @(negedge aclk);
        drive_inputs();
        #1;
        sample_outputs();
        done = (data_idx == TOTAL_REQ) && (n_mreq == TOTAL_REQ);
        cycle++;
      end
      if (!done) begin
        timeouts++;
        $display("Timeout: %0d of %0d requests and %0d bursts completed", n_mreq, TOTAL_REQ,
                 data_idx);
      end
      if (!stall_done) begin
        errors++;
        $display("Data back-pressure phase never ran");
      end
    end

    $display("Summary: %0d requests, %0d beats, %0d errors, %0d timeouts", n_mreq, n_beats,
             errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
logic/wr_pkg.sv
logic/meta_reg.sv
logic/seq_queue.sv
logic/dreq_wr_arb.sv
logic/wr_data_mux.sv
logic/wr_path_top.sv
testbench/tb_clock.sv
testbench/wr_path_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the write path testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  --top-module wr_path_tb -f sim.f -o wr_path_sim
./obj_dir/wr_path_sim 2>&1 | tee sim.log

if grep -q "Test failures found" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"
